// ==== rtl/nvram_sync_pkg.sv ====
package nvram_sync_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    // 8 kB of NvRAM, addressed per byte
    localparam int NVRAM_ADR_W  = 13;
    localparam int BYTE_W       = 8;

    // Host block buffer, 16 bit words
    localparam int SD_WORD_W    = 16;
    localparam int SD_BUF_ADR_W = 8;

    localparam int IMG_SIZE_W   = 64;

    // ======================================================================
    // Types
    // ======================================================================

    typedef logic [NVRAM_ADR_W-1:0] nvram_adr_t;
    typedef logic [BYTE_W-1:0]      nvram_byte_t;
    typedef logic [SD_WORD_W-1:0]   sd_word_t;

    typedef enum logic [3:0] {
        IDLE,
        WAIT_FOR_ACK,
        BACKUP0,
        BACKUP1,
        BACKUP2,
        BACKUP3,
        RESTORE0,
        RESTORE1,
        RESTORE2
    } nvram_state_e;

    // Block requests towards the host
    typedef struct packed {
        logic rd;
        logic wr;
    } hps_req_t;

    // Host buffer side, as seen by the bridge
    typedef struct packed {
        logic [SD_BUF_ADR_W-1:0] addr;
        sd_word_t                dout;
        logic                    wr;
    } sd_buf_t;

    typedef struct packed {
        nvram_adr_t  adr;
        nvram_byte_t restore_data;
        logic        restore_write;
    } nvram_port_t;

endpackage

// ==== rtl/nvram_mount_tracker.sv ====
module nvram_mount_tracker
    import nvram_sync_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  cditop_reset,
    input  logic                  media_change,
    input  logic [IMG_SIZE_W-1:0] img_size,
    input  logic                  nvram_cpu_changed,
    input  logic                  osd_status,
    input  logic                  backup_taken,
    output logic                  mount_pulse,
    output logic                  backup_start,
    output logic                  led_user
);

    logic mounted;
    logic img_present;

    // Set while the NvRAM content differs from the image on the card
    logic backup_pending;

    logic osd_status_q;

    assign img_present = (img_size != '0);

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            mounted        <= 1'b0;
            backup_pending <= 1'b0;
            osd_status_q   <= 1'b0;
            mount_pulse    <= 1'b0;
            backup_start   <= 1'b0;
        end else begin
            osd_status_q <= osd_status;

            // An empty image counts as unmounted
            if (media_change) begin
                mounted <= img_present;
            end
            mount_pulse <= media_change && img_present;

            // Opening the OSD is the moment to save
            backup_start <= backup_pending && osd_status && !osd_status_q;

            // Cleared once the FSM starts the backup, so a CPU change
            // during the transfer arms the next one
            if (backup_taken) begin
                backup_pending <= 1'b0;
            end else if (nvram_cpu_changed && mounted) begin
                backup_pending <= 1'b1;
            end
        end
    end

    // LED goes dark in the cycle the backup is accepted
    assign led_user = backup_pending && !backup_taken;

endmodule

// ==== rtl/nvram_sync_fsm.sv ====
module nvram_sync_fsm
    import nvram_sync_pkg::*;
(
    input  logic     clk_sys,
    input  logic     cditop_reset,
    input  logic     hps_ack,
    input  logic     sd_buf_wr,
    input  logic     mount_pulse,
    input  logic     backup_start,
    input  logic     word_advance,
    output hps_req_t hps_req,
    output logic     backup_taken,
    output logic     adr_clear,
    output logic     adr_step,
    output logic     lo_capture,
    output logic     hi_capture,
    output logic     restore_latch,
    output logic     restore_write,
    output logic     allow_cpu_access
);

    nvram_state_e state;
    logic         req_rd_q;
    logic         req_wr_q;
    logic         start_restore;
    logic         start_backup;

    // A fresh mount wins over a pending backup
    assign start_restore = (state == IDLE) && mount_pulse;
    assign start_backup  = (state == IDLE) && !mount_pulse && backup_start;
    assign backup_taken  = start_backup;

    // Request goes out in the start cycle, then the flop holds it until ack
    assign hps_req.rd = req_rd_q || start_restore;
    assign hps_req.wr = req_wr_q || start_backup;

    // ======================================================================
    // Data path strobes
    // ======================================================================

    always_comb begin
        adr_clear     = 1'b0;
        adr_step      = 1'b0;
        lo_capture    = 1'b0;
        hi_capture    = 1'b0;
        restore_latch = 1'b0;

        case (state)
            IDLE: adr_clear = 1'b1;
            // Backup walks one address ahead because of the NvRAM read latency
            BACKUP0: adr_step = 1'b1;
            BACKUP1: begin
                lo_capture = 1'b1;
                adr_step   = 1'b1;
            end
            BACKUP2: hi_capture = 1'b1;
            BACKUP3: adr_step = hps_ack && word_advance;
            RESTORE0: restore_latch = hps_ack && sd_buf_wr;
            RESTORE1: adr_step = 1'b1;
            RESTORE2: adr_step = 1'b1;
            default: begin
            end
        endcase
    end

    // ======================================================================
    // State register
    // ======================================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state            <= IDLE;
            req_rd_q         <= 1'b0;
            req_wr_q         <= 1'b0;
            restore_write    <= 1'b0;
            allow_cpu_access <= 1'b1;
        end else begin
            restore_write <= 1'b0;

            if (hps_ack) begin
                req_rd_q <= 1'b0;
                req_wr_q <= 1'b0;
            end

            case (state)
                IDLE: begin
                    allow_cpu_access <= 1'b1;
                    if (start_restore) begin
                        req_rd_q         <= 1'b1;
                        allow_cpu_access <= 1'b0;
                        state            <= WAIT_FOR_ACK;
                    end else if (start_backup) begin
                        req_wr_q         <= 1'b1;
                        allow_cpu_access <= 1'b0;
                        state            <= WAIT_FOR_ACK;
                    end
                end
                WAIT_FOR_ACK: begin
                    if (hps_ack) begin
                        state <= req_rd_q ? RESTORE0 : BACKUP0;
                    end
                end
                BACKUP0: state <= BACKUP1;
                BACKUP1: state <= BACKUP2;
                BACKUP2: state <= BACKUP3;
                BACKUP3: begin
                    // Word is complete, wait for the host to move on
                    if (!hps_ack) begin
                        state <= IDLE;
                    end else if (word_advance) begin
                        state <= BACKUP1;
                    end
                end
                RESTORE0: begin
                    if (!hps_ack) begin
                        state            <= IDLE;
                        allow_cpu_access <= 1'b1;
                    end else if (sd_buf_wr) begin
                        restore_write <= 1'b1;
                        state         <= RESTORE1;
                    end
                end
                // Low byte is written now, high byte follows
                RESTORE1: begin
                    restore_write <= 1'b1;
                    state         <= RESTORE2;
                end
                RESTORE2: state <= RESTORE0;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/nvram_adr_counter.sv ====
module nvram_adr_counter
    import nvram_sync_pkg::*;
(
    input  logic       clk_sys,
    input  logic       cditop_reset,
    input  logic       adr_clear,
    input  logic       adr_step,
    input  logic       sd_buf_adr0,
    output nvram_adr_t adr,
    output logic       word_advance
);

    // Previous value of the host buffer address LSB
    logic adr0_q;

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            adr          <= '0;
            adr0_q       <= 1'b0;
            word_advance <= 1'b0;
        end else begin
            adr0_q       <= sd_buf_adr0;
            // Any toggle of bit 0 means the host has taken the current word
            word_advance <= (sd_buf_adr0 != adr0_q);

            if (adr_clear) begin
                adr <= '0;
            end else if (adr_step) begin
                adr <= adr + nvram_adr_t'(1);
            end
        end
    end

endmodule

// ==== rtl/nvram_word_pack.sv ====
module nvram_word_pack
    import nvram_sync_pkg::*;
(
    input  logic        clk_sys,
    input  logic        lo_capture,
    input  logic        hi_capture,
    input  logic        restore_latch,
    input  logic        adr0,
    input  nvram_byte_t backup_data,
    input  sd_word_t    sd_dout,
    output sd_word_t    sd_buff_din,
    output nvram_byte_t restore_data
);

    // Last word received from the host during a restore
    sd_word_t restore_word;

    // ======================================================================
    // Backup direction
    // ======================================================================

    // Even byte fills the low half, odd byte the high half
    always_ff @(posedge clk_sys) begin
        if (lo_capture) begin
            sd_buff_din[BYTE_W-1:0] <= backup_data;
        end
        if (hi_capture) begin
            sd_buff_din[SD_WORD_W-1:BYTE_W] <= backup_data;
        end
    end

    // ======================================================================
    // Restore direction
    // ======================================================================

    always_ff @(posedge clk_sys) begin
        if (restore_latch) begin
            restore_word <= sd_dout;
        end
    end

    // Host buffer is little endian, odd address takes the upper byte
    assign restore_data = adr0 ? restore_word[SD_WORD_W-1:BYTE_W]
                               : restore_word[BYTE_W-1:0];

endmodule

// ==== rtl/nvram_sync_top.sv ====
module nvram_sync_top
    import nvram_sync_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  cditop_reset,

    // Host block transfer port
    input  logic                  hps_ack,
    input  logic                  media_change,
    input  logic [IMG_SIZE_W-1:0] img_size,
    input  sd_buf_t               sd_buf,
    output hps_req_t              hps_req,
    output sd_word_t              sd_buff_din,

    input  logic                  osd_status,

    // NvRAM side
    input  nvram_byte_t           nvram_backup_data,
    input  logic                  nvram_cpu_changed,
    output nvram_port_t           nvram,
    output logic                  allow_cpu_access,

    output logic                  led_user
);

    logic        mount_pulse;
    logic        backup_start;
    logic        backup_taken;
    logic        adr_clear;
    logic        adr_step;
    logic        word_advance;
    logic        lo_capture;
    logic        hi_capture;
    logic        restore_latch;
    logic        restore_write;
    nvram_adr_t  nvram_adr;
    nvram_byte_t restore_data;

    assign nvram = '{
        adr:           nvram_adr,
        restore_data:  restore_data,
        restore_write: restore_write
    };

    nvram_mount_tracker i_tracker (
        .clk_sys           (clk_sys),
        .cditop_reset      (cditop_reset),
        .media_change      (media_change),
        .img_size          (img_size),
        .nvram_cpu_changed (nvram_cpu_changed),
        .osd_status        (osd_status),
        .backup_taken      (backup_taken),
        .mount_pulse       (mount_pulse),
        .backup_start      (backup_start),
        .led_user          (led_user)
    );

    nvram_sync_fsm i_fsm (
        .clk_sys          (clk_sys),
        .cditop_reset     (cditop_reset),
        .hps_ack          (hps_ack),
        .sd_buf_wr        (sd_buf.wr),
        .mount_pulse      (mount_pulse),
        .backup_start     (backup_start),
        .word_advance     (word_advance),
        .hps_req          (hps_req),
        .backup_taken     (backup_taken),
        .adr_clear        (adr_clear),
        .adr_step         (adr_step),
        .lo_capture       (lo_capture),
        .hi_capture       (hi_capture),
        .restore_latch    (restore_latch),
        .restore_write    (restore_write),
        .allow_cpu_access (allow_cpu_access)
    );

    nvram_adr_counter i_adr_counter (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .adr_clear    (adr_clear),
        .adr_step     (adr_step),
        .sd_buf_adr0  (sd_buf.addr[0]),
        .adr          (nvram_adr),
        .word_advance (word_advance)
    );

    nvram_word_pack i_word_pack (
        .clk_sys       (clk_sys),
        .lo_capture    (lo_capture),
        .hi_capture    (hi_capture),
        .restore_latch (restore_latch),
        .adr0          (nvram_adr[0]),
        .backup_data   (nvram_backup_data),
        .sd_dout       (sd_buf.dout),
        .sd_buff_din   (sd_buff_din),
        .restore_data  (restore_data)
    );

endmodule

// ==== tb/nvram_sync_tb.sv ====
module nvram_sync_tb
    import nvram_sync_pkg::*;
();

    localparam int CLK_HALF     = 10;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 8917;
    localparam int NVRAM_BYTES  = 1 << NVRAM_ADR_W;
    localparam int WORD_GAP     = 4;
    localparam int QUIET_CYCLES = 20;
    localparam int NUM_ROWS     = 8;

    localparam hps_req_t REQ_NONE = '{rd: 1'b0, wr: 1'b0};
    localparam hps_req_t REQ_RD   = '{rd: 1'b1, wr: 1'b0};
    localparam hps_req_t REQ_WR   = '{rd: 1'b0, wr: 1'b1};

    typedef enum logic [2:0] {
        OP_RESTORE,
        OP_BACKUP,
        OP_ZERO_MOUNT,
        OP_UNMOUNTED_CHANGE,
        OP_RESET_PENDING
    } op_e;

    typedef struct packed {
        op_e        op;
        logic [7:0] words;
        hps_req_t   req;
    } row_t;

    // ======================================================================
    // Test table
    // ======================================================================

    // Each row relies on the mount state left by the row before
    row_t test_table [NUM_ROWS] = '{
        '{op: OP_RESTORE,          words: 8'd8,  req: REQ_RD},
        '{op: OP_BACKUP,           words: 8'd8,  req: REQ_WR},
        '{op: OP_RESTORE,          words: 8'd5,  req: REQ_RD},
        '{op: OP_BACKUP,           words: 8'd12, req: REQ_WR},
        '{op: OP_ZERO_MOUNT,       words: 8'd0,  req: REQ_NONE},
        '{op: OP_UNMOUNTED_CHANGE, words: 8'd0,  req: REQ_NONE},
        '{op: OP_RESTORE,          words: 8'd3,  req: REQ_RD},
        '{op: OP_RESET_PENDING,    words: 8'd0,  req: REQ_NONE}
    };

    logic                  clk_sys = 1'b0;
    logic                  cditop_reset;
    logic                  hps_ack;
    logic                  media_change;
    logic                  osd_status;
    logic                  nvram_cpu_changed;
    logic [IMG_SIZE_W-1:0] img_size;
    sd_buf_t               sd_buf;
    nvram_byte_t           nvram_backup_data = '0;
    hps_req_t              hps_req;
    sd_word_t              sd_buff_din;
    nvram_port_t           nvram;
    logic                  allow_cpu_access;
    logic                  led_user;

    // NvRAM model state
    nvram_byte_t mem [NVRAM_BYTES];
    nvram_adr_t  last_adr    = '0;
    int          write_count = 0;

    int errors       = 0;
    int total_errors = 0;
    int tests_run    = 0;
    int failed_tests = 0;

    always #CLK_HALF clk_sys = ~clk_sys;

    nvram_sync_top i_dut (
        .clk_sys           (clk_sys),
        .cditop_reset      (cditop_reset),
        .hps_ack           (hps_ack),
        .media_change      (media_change),
        .img_size          (img_size),
        .sd_buf            (sd_buf),
        .hps_req           (hps_req),
        .sd_buff_din       (sd_buff_din),
        .osd_status        (osd_status),
        .nvram_backup_data (nvram_backup_data),
        .nvram_cpu_changed (nvram_cpu_changed),
        .nvram             (nvram),
        .allow_cpu_access  (allow_cpu_access),
        .led_user          (led_user)
    );

    // ======================================================================
    // NvRAM model
    // ======================================================================

    // Read data follows the address of the previous cycle
    always @(negedge clk_sys) begin
        nvram_backup_data = mem[last_adr];
        last_adr          = nvram.adr;
        if (nvram.restore_write) begin
            mem[nvram.adr] = nvram.restore_data;
            write_count++;
        end
    end

    function automatic int watchdog_cycles();
        int total;
        total = RESET_CYCLES;
        foreach (test_table[i]) begin
            total += int'(test_table[i].words) * 8 + 200;
        end
        return total;
    endfunction

    function automatic string op_name(input op_e op);
        case (op)
            OP_RESTORE:          return "restore";
            OP_BACKUP:           return "backup";
            OP_ZERO_MOUNT:       return "zero size mount";
            OP_UNMOUNTED_CHANGE: return "change while unmounted";
            default:             return "reset while pending";
        endcase
    endfunction

    task automatic next_cycle();
        @(negedge clk_sys);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset();
        cditop_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        next_cycle();
        cditop_reset = 1'b0;
    endtask

    // Host request must match the expected one on every cycle of the window
    task automatic watch_request(input hps_req_t exp_req);
        repeat (QUIET_CYCLES) begin
            next_cycle();
            check_value("hps_req", 32'(hps_req), 32'(exp_req));
        end
    endtask

    // ======================================================================
    // Host operations
    // ======================================================================

    task automatic run_restore(input int n, input hps_req_t exp_req);
        sd_word_t words [$];
        int       base_writes;
        for (int k = 0; k < n; k++) begin
            words.push_back(sd_word_t'($urandom));
        end
        base_writes  = write_count;
        img_size     = IMG_SIZE_W'(NVRAM_BYTES);
        media_change = 1'b1;
        next_cycle();
        media_change = 1'b0;
        check_value("hps_req", 32'(hps_req), 32'(exp_req));
        next_cycle();
        hps_ack = 1'b1;
        next_cycle();
        check_value("hps_req", 32'(hps_req), 32'(REQ_NONE));
        foreach (words[k]) begin
            sd_buf.wr   = 1'b1;
            sd_buf.dout = words[k];
            check_value("allow_cpu_access", 32'(allow_cpu_access), 32'h0);
            repeat (WORD_GAP) begin
                next_cycle();
                sd_buf.wr = 1'b0;
            end
        end
        hps_ack = 1'b0;
        next_cycle();
        check_value("allow_cpu_access", 32'(allow_cpu_access), 32'h1);
        check_value("NvRAM write count", 32'(write_count - base_writes), 32'(2 * n));
        foreach (words[k]) begin
            check_value("nvram even byte", 32'(mem[nvram_adr_t'(2 * k)]),
                        32'(words[k][BYTE_W-1:0]));
            check_value("nvram odd byte", 32'(mem[nvram_adr_t'(2 * k + 1)]),
                        32'(words[k][SD_WORD_W-1:BYTE_W]));
        end
    endtask

    task automatic run_backup(input int n, input hps_req_t exp_req);
        sd_word_t expected;
        sd_buf.addr       = '0;
        nvram_cpu_changed = 1'b1;
        next_cycle();
        nvram_cpu_changed = 1'b0;
        check_value("led_user", 32'(led_user), 32'h1);
        osd_status = 1'b1;
        next_cycle();
        check_value("hps_req", 32'(hps_req), 32'(exp_req));
        check_value("led_user", 32'(led_user), 32'h0);
        next_cycle();
        hps_ack    = 1'b1;
        osd_status = 1'b0;
        for (int k = 0; k < n; k++) begin
            repeat (WORD_GAP) next_cycle();
            // Odd byte in the upper half
            expected = {mem[nvram_adr_t'(2 * k + 1)], mem[nvram_adr_t'(2 * k)]};
            check_value("sd_buff_din", 32'(sd_buff_din), 32'(expected));
            check_value("hps_req", 32'(hps_req), 32'(REQ_NONE));
            check_value("allow_cpu_access", 32'(allow_cpu_access), 32'h0);
            if (k == n - 1) begin
                hps_ack = 1'b0;
            end else begin
                sd_buf.addr = SD_BUF_ADR_W'(k + 1);
            end
        end
        repeat (2) next_cycle();
        check_value("allow_cpu_access", 32'(allow_cpu_access), 32'h1);
    endtask

    task automatic run_zero_mount(input hps_req_t exp_req);
        int base_writes;
        base_writes  = write_count;
        img_size     = '0;
        media_change = 1'b1;
        next_cycle();
        media_change = 1'b0;
        watch_request(exp_req);
        check_value("NvRAM write count", 32'(write_count - base_writes), 32'h0);
    endtask

    task automatic run_unmounted_change(input hps_req_t exp_req);
        nvram_cpu_changed = 1'b1;
        next_cycle();
        nvram_cpu_changed = 1'b0;
        next_cycle();
        check_value("led_user", 32'(led_user), 32'h0);
        osd_status = 1'b1;
        watch_request(exp_req);
        osd_status = 1'b0;
        check_value("led_user", 32'(led_user), 32'h0);
    endtask

    task automatic run_reset_pending(input hps_req_t exp_req);
        nvram_cpu_changed = 1'b1;
        next_cycle();
        nvram_cpu_changed = 1'b0;
        check_value("led_user", 32'(led_user), 32'h1);
        apply_reset();
        next_cycle();
        check_value("led_user", 32'(led_user), 32'h0);
        osd_status = 1'b1;
        watch_request(exp_req);
        osd_status = 1'b0;
        check_value("led_user", 32'(led_user), 32'h0);
    endtask

    task automatic finish_test(input int idx, input string name);
        tests_run++;
        total_errors += errors;
        if (errors == 0) begin
            $display("Test %0d %s: ok", idx, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: %0d error(s)", idx, name, errors);
        end
    endtask

    task automatic run_row(input int idx);
        row_t row;
        row    = test_table[idx];
        errors = 0;
        case (row.op)
            OP_RESTORE:          run_restore(int'(row.words), row.req);
            OP_BACKUP:           run_backup(int'(row.words), row.req);
            OP_ZERO_MOUNT:       run_zero_mount(row.req);
            OP_UNMOUNTED_CHANGE: run_unmounted_change(row.req);
            default:             run_reset_pending(row.req);
        endcase
        finish_test(idx + 1, $sformatf("%s (%0d words)", op_name(row.op), row.words));
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================

    initial begin : main
        cditop_reset      = 1'b1;
        hps_ack           = 1'b0;
        media_change      = 1'b0;
        osd_status        = 1'b0;
        nvram_cpu_changed = 1'b0;
        img_size          = '0;
        sd_buf            = '0;
        void'($urandom(SEED));

        for (int a = 0; a < NVRAM_BYTES; a++) begin
            mem[nvram_adr_t'(a)] = nvram_byte_t'($urandom);
        end

        apply_reset();
        next_cycle();
        check_value("hps_req", 32'(hps_req), 32'(REQ_NONE));
        check_value("restore_write", 32'(nvram.restore_write), 32'h0);
        check_value("allow_cpu_access", 32'(allow_cpu_access), 32'h1);
        check_value("led_user", 32'(led_user), 32'h0);
        finish_test(0, "after reset");

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("Tests run: %0d, failing tests: %0d, errors: %0d",
                 tests_run, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk_sys);
        $display("Timeout: the tests did not finish within %0d clock cycles", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
rtl/nvram_sync_pkg.sv
rtl/nvram_mount_tracker.sv
rtl/nvram_sync_fsm.sv
rtl/nvram_adr_counter.sv
rtl/nvram_word_pack.sv
rtl/nvram_sync_top.sv
tb/nvram_sync_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f project.f --top-module nvram_sync_tb \
    -o nvram_sync_sim > build.log 2>&1 \
    && ./obj_dir/nvram_sync_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation run did not complete"; exit 1; }

cat sim.log
grep -q "Simulation PASSED" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
